// File: monopixPkg.sv
package monopixPkg;

    // Matrix geometry, one small column array per front-end flavor
    localparam int NumFlavors   = 4;
    localparam int NumCols      = 8;
    localparam int ColAddrWidth = 3;   // Enough to address NumCols

    // Bunch-crossing timestamp, stored Gray coded in the columns
    localparam int BcidWidth = 6;

    // Readout word layout
    // Column address in the upper bits, Gray timestamp below
    localparam int DataWidth     = ColAddrWidth + BcidWidth;
    localparam int DataAddrLsb   = BcidWidth;
    localparam int DataStampLsb  = 0;

    // Fixed word returned in test-pattern mode
    localparam logic [DataWidth-1:0] TestPattern = 9'h155;

endpackage

// File: monopixConfPkg.sv
package monopixConfPkg;

    // Total length of the global configuration chain
    localparam int ConfWidth = 28;

    // Flavor enable, one bit per flavor
    localparam int EnFlavorWidth  = 4;
    localparam int EnFlavorOffset = 0;

    // HitOr output enables
    localparam int EnHitOrWidth  = 4;
    localparam int EnHitOrOffset = 4;

    // Test-pattern mode per flavor
    localparam int EnTestPatternWidth  = 4;
    localparam int EnTestPatternOffset = 8;

    // Columns that receive the injection pulse
    localparam int ColPulseSelWidth  = 8;
    localparam int ColPulseSelOffset = 12;

    // Column masks, shared by all flavors
    localparam int ColEnableWidth  = 8;
    localparam int ColEnableOffset = 20;

    // Power-up configuration
    // All flavors and columns on, pulse only column 0, no HitOr, no test pattern
    localparam logic [ConfWidth-1:0] DefaultConf = {
        8'hFF,    // ColEnable
        8'h01,    // ColPulseSel
        4'h0,     // EnTestPattern
        4'h0,     // EnHitOr
        4'hF      // EnFlavor
    };

endpackage

// File: confShiftReg.sv
`timescale 1ns/1ps

module confShiftReg (
    input  logic                                ClkBx,
    input  logic                                reset_ff,
    input  logic                                DefConf,
    input  logic                                ConfShift,
    input  logic                                ConfLoad,
    input  logic                                ConfSi,
    output logic                                ConfSo,
    output logic [monopixConfPkg::ConfWidth-1:0] ActiveConf
);

    import monopixConfPkg::*;

    logic [ConfWidth-1:0] shiftReg;   // Serial chain
    logic [ConfWidth-1:0] shadowReg;  // Loaded copy that drives the core

    // Serial input enters at bit 0 and walks up toward ConfSo
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            shiftReg <= DefaultConf;
        end else if (ConfShift) begin
            shiftReg <= {shiftReg[ConfWidth-2:0], ConfSi};
        end
    end

    // Load strobe copies the chain in one cycle
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            shadowReg <= DefaultConf;
        end else if (ConfLoad) begin
            shadowReg <= shiftReg;
        end
    end

    // Readback of the chain's top bit
    assign ConfSo = shiftReg[ConfWidth-1];

    // Default override wins over whatever was loaded
    assign ActiveConf = DefConf ? DefaultConf : shadowReg;

endmodule

// File: pixelColumns.sv
`timescale 1ns/1ps

module pixelColumns (
    input  logic                                           ClkBx,
    input  logic                                           reset_ff,
    input  logic                                           ResetBcid,
    input  logic                                           Pulse,
    input  logic [monopixPkg::NumFlavors-1:0]              Freeze,
    input  logic [monopixConfPkg::ConfWidth-1:0]           ActiveConf,
    input  logic [monopixPkg::NumFlavors-1:0]
                 [monopixPkg::NumCols-1:0]                 ClearCol,
    output logic [monopixPkg::NumFlavors-1:0]
                 [monopixPkg::NumCols-1:0]                 Pending,
    output logic [monopixPkg::NumFlavors-1:0]
                 [monopixPkg::NumCols-1:0]
                 [monopixPkg::BcidWidth-1:0]               Stamp,
    output logic [monopixPkg::NumFlavors-1:0]              HitOr
);

    import monopixPkg::*;
    import monopixConfPkg::*;

    logic [BcidWidth-1:0] bcidBin;
    logic [BcidWidth-1:0] bcidGray;
    logic                 pulseQ;
    logic                 injEdge;

    logic [EnFlavorWidth-1:0]    enFlavor;
    logic [EnHitOrWidth-1:0]     enHitOr;
    logic [ColPulseSelWidth-1:0] colPulseSel;
    logic [ColEnableWidth-1:0]   colEnable;

    logic [NumFlavors-1:0][NumCols-1:0] hitSet;

    // Configuration fields used by the matrix
    assign enFlavor    = ActiveConf[EnFlavorOffset +: EnFlavorWidth];
    assign enHitOr     = ActiveConf[EnHitOrOffset +: EnHitOrWidth];
    assign colPulseSel = ActiveConf[ColPulseSelOffset +: ColPulseSelWidth];
    assign colEnable   = ActiveConf[ColEnableOffset +: ColEnableWidth];

    // Free-running bunch-crossing counter
    always_ff @(posedge ClkBx) begin
        if (reset_ff || ResetBcid) begin
            bcidBin <= '0;
        end else begin
            bcidBin <= bcidBin + 1'b1;
        end
    end

    // Gray copy so a column latch never sees more than one bit change
    assign bcidGray = bcidBin ^ (bcidBin >> 1);

    // Rising edge of the test pulse
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            pulseQ <= 1'b0;
        end else begin
            pulseQ <= Pulse;
        end
    end

    assign injEdge = Pulse & ~pulseQ;

    // A column takes the hit only when free, selected and not frozen
    always_comb begin
        for (int f = 0; f < NumFlavors; f++) begin
            for (int c = 0; c < NumCols; c++) begin
                hitSet[f][c] = injEdge & colPulseSel[c] & colEnable[c]
                             & enFlavor[f] & ~Freeze[f] & ~Pending[f][c];
            end
        end
    end

    // Hit latches
    // Clear only targets pending columns and set only free ones
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            Pending <= '0;
        end else begin
            Pending <= (Pending & ~ClearCol) | hitSet;
        end
    end

    // Timestamp captured with the hit
    always_ff @(posedge ClkBx) begin
        for (int f = 0; f < NumFlavors; f++) begin
            for (int c = 0; c < NumCols; c++) begin
                if (hitSet[f][c]) begin
                    Stamp[f][c] <= bcidGray;
                end
            end
        end
    end

    // Fast-OR per flavor
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            HitOr <= '0;
        end else begin
            for (int f = 0; f < NumFlavors; f++) begin
                HitOr[f] <= enHitOr[f] & (|Pending[f]);
            end
        end
    end

endmodule

// File: tokenReadout.sv
`timescale 1ns/1ps

module tokenReadout (
    input  logic                                           ClkBx,
    input  logic                                           reset_ff,
    input  logic [monopixPkg::NumFlavors-1:0]              Read,
    input  logic [monopixPkg::NumFlavors-1:0]
                 [monopixPkg::NumCols-1:0]                 Pending,
    input  logic [monopixPkg::NumFlavors-1:0]
                 [monopixPkg::NumCols-1:0]
                 [monopixPkg::BcidWidth-1:0]               Stamp,
    input  logic [monopixConfPkg::ConfWidth-1:0]           ActiveConf,
    output logic [monopixPkg::NumFlavors-1:0]
                 [monopixPkg::NumCols-1:0]                 ClearCol,
    output logic [monopixPkg::NumFlavors-1:0]              Token,
    output logic [monopixPkg::NumFlavors-1:0]
                 [monopixPkg::DataWidth-1:0]               DataOut,
    output logic [monopixPkg::NumFlavors-1:0]              DataValid
);

    import monopixPkg::*;
    import monopixConfPkg::*;

    logic [EnTestPatternWidth-1:0]           enTestPattern;
    logic [NumFlavors-1:0]                   anyPending;
    logic [NumFlavors-1:0]                   readHit;   // Read that finds a column
    logic [NumFlavors-1:0][ColAddrWidth-1:0] selCol;

    assign enTestPattern = ActiveConf[EnTestPatternOffset +: EnTestPatternWidth];

    // Priority pick of the lowest pending column per flavor
    always_comb begin
        for (int f = 0; f < NumFlavors; f++) begin
            anyPending[f] = |Pending[f];
            selCol[f]     = '0;
            for (int c = NumCols - 1; c >= 0; c--) begin
                if (Pending[f][c]) begin
                    selCol[f] = c[ColAddrWidth-1:0];
                end
            end
        end
    end

    assign readHit = Read & anyPending;

    // Release the chosen column on the same edge the word is taken
    always_comb begin
        ClearCol = '0;
        for (int f = 0; f < NumFlavors; f++) begin
            if (readHit[f]) begin
                ClearCol[f][selCol[f]] = 1'b1;
            end
        end
    end

    // Token follows pending with one cycle of delay
    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            Token     <= '0;
            DataValid <= '0;
        end else begin
            Token     <= anyPending;
            DataValid <= readHit;   // Single cycle per read
        end
    end

    // Data word, address above the stamp
    always_ff @(posedge ClkBx) begin
        for (int f = 0; f < NumFlavors; f++) begin
            if (readHit[f]) begin
                if (enTestPattern[f]) begin
                    DataOut[f] <= TestPattern;
                end else begin
                    DataOut[f][DataAddrLsb +: ColAddrWidth] <= selCol[f];
                    DataOut[f][DataStampLsb +: BcidWidth]   <= Stamp[f][selCol[f]];
                end
            end
        end
    end

endmodule

// File: monopixTop.sv
`timescale 1ns/1ps

module monopixTop (
    input  logic                                           ClkBx,
    input  logic                                           reset_ff,
    input  logic                                           DefConf,
    input  logic                                           ConfShift,
    input  logic                                           ConfLoad,
    input  logic                                           ConfSi,
    input  logic                                           ResetBcid,
    input  logic                                           Pulse,
    input  logic [monopixPkg::NumFlavors-1:0]              Read,
    input  logic [monopixPkg::NumFlavors-1:0]              Freeze,
    output logic                                           ConfSo,
    output logic [monopixPkg::NumFlavors-1:0]              Token,
    output logic [monopixPkg::NumFlavors-1:0]
                 [monopixPkg::DataWidth-1:0]               DataOut,
    output logic [monopixPkg::NumFlavors-1:0]              DataValid,
    output logic [monopixPkg::NumFlavors-1:0]              HitOr
);

    import monopixPkg::*;
    import monopixConfPkg::*;

    logic [ConfWidth-1:0]                         activeConf;
    logic [NumFlavors-1:0][NumCols-1:0]           pending;
    logic [NumFlavors-1:0][NumCols-1:0]           clearCol;
    logic [NumFlavors-1:0][NumCols-1:0][BcidWidth-1:0] stamp;

    // Global configuration chain
    confShiftReg uConf (
        .ClkBx      (ClkBx),
        .reset_ff   (reset_ff),
        .DefConf    (DefConf),
        .ConfShift  (ConfShift),
        .ConfLoad   (ConfLoad),
        .ConfSi     (ConfSi),
        .ConfSo     (ConfSo),
        .ActiveConf (activeConf)
    );

    // Column arrays of all four flavors
    pixelColumns uColumns (
        .ClkBx      (ClkBx),
        .reset_ff   (reset_ff),
        .ResetBcid  (ResetBcid),
        .Pulse      (Pulse),
        .Freeze     (Freeze),
        .ActiveConf (activeConf),
        .ClearCol   (clearCol),
        .Pending    (pending),
        .Stamp      (stamp),
        .HitOr      (HitOr)
    );

    // Token readout, one channel per flavor
    tokenReadout uReadout (
        .ClkBx      (ClkBx),
        .reset_ff   (reset_ff),
        .Read       (Read),
        .Pending    (pending),
        .Stamp      (stamp),
        .ActiveConf (activeConf),
        .ClearCol   (clearCol),
        .Token      (Token),
        .DataOut    (DataOut),
        .DataValid  (DataValid)
    );

endmodule

// File: monopixTop_assertions.sv
`timescale 1ns/1ps

module monopixTop_assertions (
    input logic                                  ClkBx,
    input logic                                  reset_ff,
    input logic [monopixPkg::NumFlavors-1:0]     Read,
    input logic [monopixPkg::NumFlavors-1:0]     Token,
    input logic [monopixPkg::NumFlavors-1:0]     DataValid,
    input logic [monopixPkg::NumFlavors-1:0]     HitOr,
    input logic [monopixConfPkg::ConfWidth-1:0]  activeConf
);

    import monopixConfPkg::*;

    logic [EnHitOrWidth-1:0] enHitOr;

    int validFails = 0;
    int widthFails = 0;
    int resetFails = 0;
    int hitOrFails = 0;
    int failCount;

    assign enHitOr   = activeConf[EnHitOrOffset +: EnHitOrWidth];
    assign failCount = validFails + widthFails + resetFails + hitOrFails;

    // Each word answers a Read from the edge before
    aValidAfterRead: assert property (@(posedge ClkBx) disable iff (reset_ff)
        (DataValid & ~$past(Read)) == '0)
    else begin
        $error("DataValid without a Read on the previous edge");
        validFails++;
    end

    // A word burst never outlasts the token
    aValidWidth: assert property (@(posedge ClkBx) disable iff (reset_ff)
        (DataValid & ~Token) == '0)
    else begin
        $error("DataValid high without the Token of its flavor");
        widthFails++;
    end

    // Outputs quiet right after reset
    aQuietAfterReset: assert property (@(posedge ClkBx)
        $fell(reset_ff) |-> (Token == '0 && DataValid == '0 && HitOr == '0))
    else begin
        $error("Token, DataValid or HitOr high after reset");
        resetFails++;
    end

    aHitOrGated: assert property (@(posedge ClkBx) disable iff (reset_ff)
        (HitOr & ~$past(enHitOr)) == '0)   // Registered, so gate from one edge back
    else begin
        $error("HitOr high with its enable cleared");
        hitOrFails++;
    end

endmodule

// File: tb.sv
`timescale 1ns/1ps

module tb;

    import monopixPkg::*;
    import monopixConfPkg::*;

    logic                                   ClkBx = 1'b0;
    logic                                   reset_ff;
    logic                                   DefConf;
    logic                                   ConfShift;
    logic                                   ConfLoad;
    logic                                   ConfSi;
    logic                                   ResetBcid;
    logic                                   Pulse;
    logic [NumFlavors-1:0]                  Read;
    logic [NumFlavors-1:0]                  Freeze;
    logic                                   ConfSo;
    logic [NumFlavors-1:0]                  Token;
    logic [NumFlavors-1:0][DataWidth-1:0]   DataOut;
    logic [NumFlavors-1:0]                  DataValid;
    logic [NumFlavors-1:0]                  HitOr;

    // Reference model state
    logic [BcidWidth-1:0]                               modelBcid;
    logic [NumFlavors-1:0][NumCols-1:0]                 modelPending;
    logic [NumFlavors-1:0][NumCols-1:0][BcidWidth-1:0]  modelStamp;
    logic [ConfWidth-1:0]                               modelActive;

    int    cycleCount = 0;
    int    cycleLimit = 6 * 300 + 200;  // Six tests of at most 300 cycles, plus reset
    int    caseErrs;
    int    passedCases;
    int    failedCases;
    string caseName;

    monopixTop uut (
        .ClkBx     (ClkBx),
        .reset_ff  (reset_ff),
        .DefConf   (DefConf),
        .ConfShift (ConfShift),
        .ConfLoad  (ConfLoad),
        .ConfSi    (ConfSi),
        .ResetBcid (ResetBcid),
        .Pulse     (Pulse),
        .Read      (Read),
        .Freeze    (Freeze),
        .ConfSo    (ConfSo),
        .Token     (Token),
        .DataOut   (DataOut),
        .DataValid (DataValid),
        .HitOr     (HitOr)
    );

    bind monopixTop monopixTop_assertions uAssert (
        .ClkBx      (ClkBx),
        .reset_ff   (reset_ff),
        .Read       (Read),
        .Token      (Token),
        .DataValid  (DataValid),
        .HitOr      (HitOr),
        .activeConf (activeConf)
    );

    always #50 ClkBx = ~ClkBx;

    // Counter model, restarts on reset and ResetBcid
    always @(posedge ClkBx) begin
        if (reset_ff || ResetBcid) begin
            modelBcid <= '0;
        end else begin
            modelBcid <= modelBcid + 1'b1;
        end
    end

    always @(posedge ClkBx) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Run stopped, no end after %0d cycles", cycleCount);
            $display(">>> FAIL");
            $finish;
        end
    end

    function automatic logic [BcidWidth-1:0] toGray(input logic [BcidWidth-1:0] b);
        logic [BcidWidth-1:0] g;
        g[BcidWidth-1] = b[BcidWidth-1];
        for (int i = 0; i < BcidWidth - 1; i++) begin
            g[i] = b[i+1] ^ b[i];   // Neighbouring bits differ
        end
        return g;
    endfunction

    function automatic logic [ConfWidth-1:0] effectiveConf();
        return DefConf ? DefaultConf : modelActive;
    endfunction

    function automatic int lowestPending(input int f);
        for (int c = 0; c < NumCols; c++) begin
            if (modelPending[f][c]) begin
                return c;
            end
        end
        return -1;
    endfunction

    function automatic logic [DataWidth-1:0] expectedWord(input int f, input int c);
        logic [ConfWidth-1:0]    conf;
        logic [ColAddrWidth-1:0] addr;
        conf = effectiveConf();
        addr = c[ColAddrWidth-1:0];
        if (conf[EnTestPatternOffset + f]) begin
            return TestPattern;
        end
        return {addr, modelStamp[f][c]};
    endfunction

    task automatic reportMismatch(input string sig, input logic [31:0] got,
                                  input logic [31:0] exp);
        $display("** Error: %s = 0x%0h, expected 0x%0h", sig, got, exp);
        caseErrs++;
    endtask

    task automatic noteFailure(input string msg);
        $display("%s", msg);
        caseErrs++;
    endtask

    task automatic openCase(input string name);
        caseName = name;
        caseErrs = 0;
    endtask

    task automatic closeCase();
        if (caseErrs == 0) begin
            $display("test %s: ok", caseName);
            passedCases++;
        end else begin
            $display("test %s: %0d errors", caseName, caseErrs);
            failedCases++;
        end
    endtask

    task automatic applyReset();
        reset_ff = 1'b1;
        repeat (4) @(negedge ClkBx);
        reset_ff     = 1'b0;
        modelPending = '0;
        modelActive  = DefaultConf;
    endtask

    // MSB first, ConfSo sampled before each shift
    task automatic shiftWord(input logic [ConfWidth-1:0] w, output logic [ConfWidth-1:0] back);
        for (int i = ConfWidth - 1; i >= 0; i--) begin
            back[i]   = ConfSo;
            ConfSi    = w[i];
            ConfShift = 1'b1;
            @(negedge ClkBx);
        end
        ConfShift = 1'b0;
    endtask

    task automatic writeConf(input logic [ConfWidth-1:0] w);
        logic [ConfWidth-1:0] back;
        shiftWord(w, back);
        ConfLoad = 1'b1;
        @(negedge ClkBx);
        ConfLoad    = 1'b0;
        modelActive = w;
    endtask

    task automatic inject();
        logic [ConfWidth-1:0] conf;
        logic [BcidWidth-1:0] stampNow;
        conf = effectiveConf();
        @(negedge ClkBx);
        Pulse    = 1'b1;
        stampNow = toGray(modelBcid);   // Value held at the sampling edge
        for (int f = 0; f < NumFlavors; f++) begin
            for (int c = 0; c < NumCols; c++) begin
                if (conf[ColPulseSelOffset + c] && conf[ColEnableOffset + c]
                    && conf[EnFlavorOffset + f] && !Freeze[f] && !modelPending[f][c]) begin
                    modelPending[f][c] = 1'b1;
                    modelStamp[f][c]   = stampNow;
                end
            end
        end
        @(negedge ClkBx);
        Pulse = 1'b0;
    endtask

    task automatic checkIdle(input int f);
        assert (!Token[f]) else reportMismatch($sformatf("Token[%0d]", f), 32'(Token[f]), 32'h0);
        Read[f] = 1'b1;
        @(negedge ClkBx);
        assert (!DataValid[f]) else noteFailure($sformatf("Word from idle flavor %0d", f));
        Read[f] = 1'b0;
    endtask

    task automatic readFlavor(input int f);
        int                   waitCycles;
        int                   c;
        logic [DataWidth-1:0] exp;
        if (modelPending[f] == '0) begin
            checkIdle(f);
            return;
        end
        waitCycles = 0;
        while (!Token[f] && waitCycles < 8) begin
            @(negedge ClkBx);
            waitCycles++;
        end
        assert (Token[f]) else noteFailure($sformatf("Token of flavor %0d never rose", f));
        Read[f] = 1'b1;   // Held high, one word per cycle
        while (modelPending[f] != '0) begin
            @(negedge ClkBx);
            c   = lowestPending(f);
            exp = expectedWord(f, c);
            assert (DataValid[f]) else noteFailure($sformatf("Flavor %0d missed a word", f));
            assert (DataOut[f] == exp)
                else reportMismatch($sformatf("DataOut[%0d]", f), 32'(DataOut[f]), 32'(exp));
            modelPending[f][c] = 1'b0;
        end
        Read[f]    = 1'b0;
        waitCycles = 0;
        while (Token[f] && waitCycles < 8) begin
            @(negedge ClkBx);
            waitCycles++;
        end
        assert (!Token[f]) else noteFailure($sformatf("Token of flavor %0d stuck high", f));
    endtask

    task automatic readAll();
        for (int f = 0; f < NumFlavors; f++) begin
            readFlavor(f);
        end
    endtask

    initial begin
        logic [31:0]                 randWord;
        logic [ConfWidth-1:0]        first;
        logic [ConfWidth-1:0]        conf;
        logic [ConfWidth-1:0]        back;
        logic [ColPulseSelWidth-1:0] sel;
        logic [NumFlavors-1:0]       hitExp;
        randWord    = $urandom(16000);
        reset_ff    = 1'b1;
        DefConf     = 1'b0;
        ConfShift   = 1'b0;
        ConfLoad    = 1'b0;
        ConfSi      = 1'b0;
        ResetBcid   = 1'b0;
        Pulse       = 1'b0;
        Read        = '0;
        Freeze      = '0;
        passedCases = 0;
        failedCases = 0;
        applyReset();

        openCase("configuration readback");
        randWord = $urandom;
        first    = randWord[ConfWidth-1:0];
        randWord = $urandom;
        conf     = randWord[ConfWidth-1:0];
        shiftWord(first, back);
        shiftWord(conf, back);
        assert (back == first) else reportMismatch("ConfSo", 32'(back), 32'(first));
        ConfLoad = 1'b1;
        @(negedge ClkBx);
        ConfLoad    = 1'b0;
        modelActive = conf;
        inject();
        readAll();
        closeCase();

        openCase("default configuration");
        DefConf = 1'b1;
        applyReset();
        writeConf({8'h00, 8'hFE, 4'hF, 4'hF, 4'h0});  // Loaded but overridden
        inject();
        readAll();
        DefConf = 1'b0;
        closeCase();

        openCase("multi-column readout");
        randWord = $urandom;
        sel      = randWord[ColPulseSelWidth-1:0];
        if (sel == '0) begin
            sel = 8'h81;
        end
        writeConf({8'hFF, sel, 4'h0, 4'h0, 4'hF});
        inject();
        readAll();
        closeCase();

        openCase("freeze and flavor disable");
        writeConf({8'hFF, 8'h0F, 4'h0, 4'h0, 4'b1011});  // Flavor 2 off
        Freeze = 4'b0001;
        inject();
        Freeze = '0;
        @(negedge ClkBx);   // Token would rise here
        readAll();
        closeCase();

        openCase("bcid reset");
        randWord = $urandom;
        writeConf({8'hFF, randWord[7:0] | 8'h10, 4'h0, 4'h0, 4'hF});
        repeat (randWord[11:8] + 3) @(negedge ClkBx);
        ResetBcid = 1'b1;
        @(negedge ClkBx);
        ResetBcid = 1'b0;
        inject();
        readAll();
        closeCase();

        openCase("test pattern and hitor");
        conf = {8'hFF, 8'h05, 4'b0011, 4'b0101, 4'hF};
        writeConf(conf);
        inject();
        @(negedge ClkBx);
        for (int f = 0; f < NumFlavors; f++) begin
            hitExp[f] = conf[EnHitOrOffset + f] & (modelPending[f] != '0);
        end
        assert (HitOr == hitExp) else reportMismatch("HitOr", 32'(HitOr), 32'(hitExp));
        readAll();
        assert (HitOr == '0) else reportMismatch("HitOr", 32'(HitOr), 32'h0);
        closeCase();

        repeat (3) @(negedge ClkBx);
        $display("tests passed %0d, failed %0d, assertion failures %0d",
                 passedCases, failedCases, uut.uAssert.failCount);
        if (failedCases == 0 && uut.uAssert.failCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: tb.f
monopixPkg.sv
monopixConfPkg.sv
confShiftReg.sv
pixelColumns.sv
tokenReadout.sv
monopixTop.sv
monopixTop_assertions.sv
tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb
FILELIST = tb.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log for the pass line"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -qx ">>> PASS" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
